// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vtb_rv32_decode

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_rv32_decode -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: sim/tb_rv32_decode.sv
module tb_rv32_decode import rv32_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic         clk;
    logic         rst_i;
    logic         stall_i;
    logic         flush_i;
    word_t        pc_i;
    word_t        instr_i;
    rf_write_t    wb_i;
    logic         valid_o;
    reg_idx_t     rs1_o;
    reg_idx_t     rs2_o;
    reg_idx_t     rd_o;
    decode_ctrl_t ctrl_o;
    word_t        pc_o;
    word_t        imm_o;
    word_t        rs1_value_o;
    word_t        rs2_value_o;

    word_t seed = 32'h6e9f0cb4;

    rv32_decode u_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .pc_i        (pc_i),
        .instr_i     (instr_i),
        .wb_i        (wb_i),
        .valid_o     (valid_o),
        .rs1_o       (rs1_o),
        .rs2_o       (rs2_o),
        .rd_o        (rd_o),
        .ctrl_o      (ctrl_o),
        .pc_o        (pc_o),
        .imm_o       (imm_o),
        .rs1_value_o (rs1_value_o),
        .rs2_value_o (rs2_value_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // outputs settle, inputs may change.
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic fail_run();
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic compare_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            fail_run();
        end
    endtask

    task automatic compare_ctrl(input string name, input decode_ctrl_t exp,
                                input decode_ctrl_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            fail_run();
        end
    endtask

    // random register and immediate bits around the given fields.
    function automatic word_t make_instr(input opcode_t op, input funct3_t f3, input funct7_t f7);
        word_t r;
        r = next_rand();
        return {f7, r[24:15], f3, r[11:7], op};
    endfunction

    function automatic alu_op_t alu_for_funct3(input funct3_t f3);
        case (f3)
            3'd0:    return ALU_OP_ADD_SUB;
            3'd1:    return ALU_OP_SLL;
            3'd2:    return ALU_OP_SLT;
            3'd3:    return ALU_OP_SLTU;
            3'd4:    return ALU_OP_XOR;
            3'd5:    return ALU_OP_SRL_SRA;
            3'd6:    return ALU_OP_OR;
            default: return ALU_OP_AND;
        endcase
    endfunction

    function automatic void model_decode(input word_t instr, output logic valid,
                                         output decode_ctrl_t ctrl, output word_t imm);
        opcode_t  op;
        funct3_t  f3;
        funct7_t  f7;
        imm_fmt_t fmt;
        op    = instr[6:0];
        f3    = instr[14:12];
        f7    = instr[31:25];
        valid = 1'b0;
        ctrl  = CTRL_DEFAULT;
        fmt   = IMM_FMT_NONE;
        case (op)
            OPCODE_LUI, OPCODE_AUIPC: begin
                valid             = 1'b1;
                ctrl.alu_op       = (op == OPCODE_LUI) ? ALU_OP_SRC2 : ALU_OP_ADD_SUB;
                ctrl.alu_src1     = (op == OPCODE_LUI) ? ALU_SRC1_REG : ALU_SRC1_PC;
                ctrl.alu_src2     = ALU_SRC2_IMM;
                ctrl.rd_writeback = 1'b1;
                fmt               = IMM_FMT_U;
            end
            OPCODE_JAL, OPCODE_JALR: begin
                valid              = (op == OPCODE_JAL) || (f3 == 3'b000);
                ctrl.alu_op        = ALU_OP_SRC1P4;
                ctrl.alu_src1      = ALU_SRC1_PC;
                ctrl.branch_op     = BRANCH_OP_ALWAYS;
                ctrl.rd_writeback  = 1'b1;
                ctrl.branch_pc_src = (op == OPCODE_JAL) ? BRANCH_PC_SRC_IMM : BRANCH_PC_SRC_REG;
                fmt                = (op == OPCODE_JAL) ? IMM_FMT_J : IMM_FMT_I;
            end
            OPCODE_BRANCH: begin
                valid            = (f3 != 3'b010) && (f3 != 3'b011);
                ctrl.alu_sub_sra = 1'b1;
                ctrl.alu_op      = f3[2] ? (f3[1] ? ALU_OP_SLTU : ALU_OP_SLT) : ALU_OP_ADD_SUB;
                ctrl.branch_op   = (f3 == FUNCT3_BEQ || f3 == FUNCT3_BGE || f3 == FUNCT3_BGEU) ?
                                   BRANCH_OP_ZERO : BRANCH_OP_NON_ZERO;
                fmt              = IMM_FMT_B;
            end
            OPCODE_LOAD, OPCODE_STORE: begin
                ctrl.alu_src2 = ALU_SRC2_IMM;
                case (f3[1:0])
                    2'd0:    ctrl.mem_width = MEM_WIDTH_BYTE;
                    2'd1:    ctrl.mem_width = MEM_WIDTH_HALF;
                    default: ctrl.mem_width = MEM_WIDTH_WORD;
                endcase
                if (op == OPCODE_LOAD) begin
                    valid                = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
                    ctrl.mem_read_en     = 1'b1;
                    ctrl.rd_writeback    = 1'b1;
                    ctrl.mem_zero_extend = (f3 == FUNCT3_LBU) || (f3 == FUNCT3_LHU);
                    fmt                  = IMM_FMT_I;
                end else begin
                    valid             = f3 inside {3'd0, 3'd1, 3'd2};
                    ctrl.mem_write_en = 1'b1;
                    fmt               = IMM_FMT_S;
                end
            end
            OPCODE_OP_IMM: begin
                ctrl.alu_op       = alu_for_funct3(f3);
                ctrl.alu_src2     = ALU_SRC2_IMM;
                ctrl.rd_writeback = 1'b1;
                ctrl.alu_sub_sra  = (f3 == FUNCT3_SLT) || (f3 == FUNCT3_SLTU);
                if (f3 == FUNCT3_SLL) begin
                    valid = (f7 == FUNCT7_ZERO);
                    fmt   = IMM_FMT_SHAMT;
                end else if (f3 == FUNCT3_SRL_SRA) begin
                    valid            = (f7 == FUNCT7_ZERO) || (f7 == FUNCT7_SUB_SRA);
                    ctrl.alu_sub_sra = (f7 == FUNCT7_SUB_SRA);
                    fmt              = IMM_FMT_SHAMT;
                end else begin
                    valid = 1'b1;
                    fmt   = IMM_FMT_I;
                end
            end
            OPCODE_OP: begin
                ctrl.alu_op       = alu_for_funct3(f3);
                ctrl.rd_writeback = 1'b1;
                ctrl.alu_sub_sra  = (f3 == FUNCT3_SLT) || (f3 == FUNCT3_SLTU) ||
                                    (f7 == FUNCT7_SUB_SRA);
                valid = (f7 == FUNCT7_ZERO) || ((f7 == FUNCT7_SUB_SRA) &&
                        (f3 == FUNCT3_ADD_SUB || f3 == FUNCT3_SRL_SRA));
            end
            OPCODE_MISC_MEM: valid = (f3 == FUNCT3_FENCE) || (f3 == FUNCT3_FENCE_I);
            default:         valid = 1'b0;
        endcase
        if (!valid) begin
            ctrl = CTRL_DEFAULT;
            fmt  = IMM_FMT_NONE;
        end
        case (fmt)
            IMM_FMT_I:     imm = word_t'($signed(instr) >>> 20);
            IMM_FMT_S:     imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_FMT_B:     imm = word_t'($signed({instr[31], instr[7], instr[30:25],
                                                  instr[11:8], 1'b0, 19'd0}) >>> 19);
            IMM_FMT_U:     imm = instr & 32'hfffff000;
            IMM_FMT_J:     imm = word_t'($signed({instr[31], instr[19:12], instr[20],
                                                  instr[30:21], 1'b0, 11'd0}) >>> 11);
            IMM_FMT_SHAMT: imm = {27'd0, instr[24:20]};
            default:       imm = '0;
        endcase
    endfunction

    task automatic check_decode(input string name, input word_t instr, input word_t pc,
                                input logic flush);
        logic         exp_valid;
        decode_ctrl_t exp_ctrl;
        word_t        exp_imm;
        model_decode(instr, exp_valid, exp_ctrl, exp_imm);
        if (flush) begin
            exp_ctrl.mem_read_en  = 1'b0;
            exp_ctrl.mem_write_en = 1'b0;
            exp_ctrl.branch_op    = BRANCH_OP_NEVER;
            exp_ctrl.rd_writeback = 1'b0;
        end
        compare_bit({name, " valid"}, exp_valid, valid_o);
        compare_ctrl({name, " ctrl"}, exp_ctrl, ctrl_o);
        compare_word({name, " imm"}, exp_imm, imm_o);
        compare_word({name, " pc"}, pc, pc_o);
        compare_idx({name, " rs1"}, flush ? 5'd0 : instr[19:15], rs1_o);
        compare_idx({name, " rs2"}, flush ? 5'd0 : instr[24:20], rs2_o);
        compare_idx({name, " rd"}, instr[11:7], rd_o);
    endtask

    task automatic run_instr(input string name, input word_t instr, input logic flush);
        word_t pc;
        pc      = next_rand() & ~32'h3;
        instr_i = instr;
        pc_i    = pc;
        flush_i = flush;
        step_cycle();
        flush_i = 1'b0;
        check_decode(name, instr, pc, flush);
    endtask

    task automatic write_reg(input reg_idx_t rd, input word_t value);
        wb_i.rd    = rd;
        wb_i.en    = 1'b1;
        wb_i.value = value;
        step_cycle();
        wb_i.en = 1'b0;
    endtask

    task automatic test_reset();
        int n;
        n = 0;
        repeat (3) @(posedge clk);
        #2;
        while (valid_o !== 1'b0) begin
            step_cycle();
            n++;
            if (n > 10) begin
                $display("timeout waiting for reset to clear valid_o");
                fail_run();
            end
        end
        compare_ctrl("reset ctrl", CTRL_DEFAULT, ctrl_o);
        rst_i = 1'b0;
    endtask

    task automatic test_regfile();
        word_t v5;
        word_t v6;
        word_t v7;
        v5 = next_rand();
        v6 = next_rand();
        v7 = next_rand();
        write_reg(5'd5, v5);
        write_reg(5'd6, v6);
        write_reg(5'd0, next_rand());
        instr_i = {7'd0, 5'd6, 5'd5, 3'd0, 5'd1, OPCODE_OP};
        step_cycle();
        compare_word("regfile x5", v5, rs1_value_o);
        compare_word("regfile x6", v6, rs2_value_o);
        instr_i = {7'd0, 5'd5, 5'd0, 3'd0, 5'd1, OPCODE_OP};
        step_cycle();
        compare_word("regfile x0", 32'd0, rs1_value_o);
        compare_word("regfile x5 rs2", v5, rs2_value_o);
        // write and read of x7 on one edge.
        wb_i.rd    = 5'd7;
        wb_i.en    = 1'b1;
        wb_i.value = v7;
        instr_i    = {7'd0, 5'd7, 5'd7, 3'd0, 5'd1, OPCODE_OP};
        step_cycle();
        wb_i.en = 1'b0;
        compare_word("regfile bypass rs1", v7, rs1_value_o);
        compare_word("regfile bypass rs2", v7, rs2_value_o);
    endtask

    task automatic test_alu_groups();
        word_t   r;
        funct7_t f7;
        int      f;
        int      k;
        for (f = 0; f < 8; f++) begin
            for (k = 0; k < 3; k++) begin
                r  = next_rand();
                f7 = (k == 0) ? FUNCT7_ZERO : (k == 1) ? FUNCT7_SUB_SRA : {1'b1, r[5:0]};
                run_instr($sformatf("op f3 %0d f7 %h", f, f7),
                          make_instr(OPCODE_OP, funct3_t'(f), f7), 1'b0);
                run_instr($sformatf("op_imm f3 %0d f7 %h", f, f7),
                          make_instr(OPCODE_OP_IMM, funct3_t'(f), f7), 1'b0);
            end
        end
    endtask

    task automatic test_other_groups();
        opcode_t ops [8];
        word_t   r;
        int      i;
        int      f;
        int      s;
        ops[0] = OPCODE_BRANCH;
        ops[1] = OPCODE_LOAD;
        ops[2] = OPCODE_STORE;
        ops[3] = OPCODE_JAL;
        ops[4] = OPCODE_JALR;
        ops[5] = OPCODE_LUI;
        ops[6] = OPCODE_AUIPC;
        ops[7] = OPCODE_MISC_MEM;
        for (i = 0; i < 8; i++) begin
            for (f = 0; f < 8; f++) begin
                for (s = 0; s < 2; s++) begin // sign bit clear, then set.
                    r = next_rand();
                    run_instr($sformatf("opcode %h f3 %0d sign %0d", ops[i], f, s),
                              make_instr(ops[i], funct3_t'(f), {s[0], r[5:0]}), 1'b0);
                end
            end
        end
        run_instr("fence", make_instr(OPCODE_MISC_MEM, FUNCT3_FENCE, 7'd0), 1'b0);
        compare_bit("fence valid", 1'b1, valid_o);
        compare_ctrl("fence ctrl", CTRL_DEFAULT, ctrl_o);
        run_instr("fence.i", make_instr(OPCODE_MISC_MEM, FUNCT3_FENCE_I, 7'd0), 1'b0);
        compare_bit("fence.i valid", 1'b1, valid_o);
        compare_ctrl("fence.i ctrl", CTRL_DEFAULT, ctrl_o);
    endtask

    task automatic check_illegal(input string name, input word_t instr);
        run_instr(name, instr, 1'b0);
        compare_bit({name, " valid"}, 1'b0, valid_o);
        compare_ctrl({name, " ctrl"}, CTRL_DEFAULT, ctrl_o);
        compare_word({name, " imm"}, 32'd0, imm_o);
    endtask

    task automatic test_illegal();
        check_illegal("unknown opcode", make_instr(7'b1111111, 3'd0, 7'd0));
        check_illegal("add bad funct7", make_instr(OPCODE_OP, FUNCT3_ADD_SUB, 7'b0000001));
        check_illegal("slli funct7", make_instr(OPCODE_OP_IMM, FUNCT3_SLL, FUNCT7_SUB_SRA));
        check_illegal("jalr funct3", make_instr(OPCODE_JALR, 3'b010, 7'd0));
    endtask

    task automatic test_stall();
        word_t        a;
        word_t        b;
        word_t        b_pc;
        logic         s_valid;
        decode_ctrl_t s_ctrl;
        word_t        s_imm;
        word_t        s_pc;
        word_t        s_v1;
        word_t        s_v2;
        reg_idx_t     s_rs1;
        reg_idx_t     s_rs2;
        reg_idx_t     s_rd;
        a = make_instr(OPCODE_LOAD, FUNCT3_LW, 7'h15);
        run_instr("stall setup", a, 1'b0);
        s_valid = valid_o;
        s_ctrl  = ctrl_o;
        s_imm   = imm_o;
        s_pc    = pc_o;
        s_v1    = rs1_value_o;
        s_v2    = rs2_value_o;
        s_rs1   = rs1_o;
        s_rs2   = rs2_o;
        s_rd    = rd_o;
        b       = make_instr(OPCODE_BRANCH, FUNCT3_BNE, 7'h40);
        b_pc    = next_rand() & ~32'h3;
        stall_i = 1'b1;
        instr_i = b;
        pc_i    = b_pc;
        wb_i.rd    = a[19:15]; // read value must stay held.
        wb_i.en    = 1'b1;
        wb_i.value = ~s_v1;
        repeat (3) begin
            step_cycle();
            compare_bit("stall valid", s_valid, valid_o);
            compare_ctrl("stall ctrl", s_ctrl, ctrl_o);
            compare_word("stall imm", s_imm, imm_o);
            compare_word("stall pc", s_pc, pc_o);
            compare_word("stall rs1 value", s_v1, rs1_value_o);
            compare_word("stall rs2 value", s_v2, rs2_value_o);
            compare_idx("stall rs1", s_rs1, rs1_o);
            compare_idx("stall rs2", s_rs2, rs2_o);
            compare_idx("stall rd", s_rd, rd_o);
        end
        wb_i.en = 1'b0;
        stall_i = 1'b0;
        step_cycle();
        check_decode("stall release", b, b_pc, 1'b0);
    endtask

    task automatic test_flush();
        run_instr("flush store", make_instr(OPCODE_STORE, FUNCT3_SW, 7'h2a), 1'b1);
        run_instr("flush load", make_instr(OPCODE_LOAD, FUNCT3_LHU, 7'h51), 1'b1);
        run_instr("flush jal", make_instr(OPCODE_JAL, 3'd3, 7'h0c), 1'b1);
        run_instr("after flush", make_instr(OPCODE_STORE, FUNCT3_SB, 7'h7f), 1'b0);
    endtask

    initial begin
        rst_i   = 1'b1;
        stall_i = 1'b0;
        flush_i = 1'b0;
        pc_i    = '0;
        instr_i = make_instr(OPCODE_LOAD, FUNCT3_LW, 7'd0); // valid load for reset to clear.
        wb_i    = '0;
        test_reset();
        test_regfile();
        test_alu_groups();
        test_other_groups();
        test_illegal();
        test_stall();
        test_flush();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: sources.f
verilog/rv32_pkg.sv
verilog/rv32_ctrl_decode.sv
verilog/rv32_imm_gen.sv
verilog/rv32_regfile.sv
verilog/rv32_decode.sv
sim/tb_rv32_decode.sv

// File: verilog/rv32_ctrl_decode.sv
module rv32_ctrl_decode import rv32_pkg::*; (
    input  opcode_t      opcode_i,
    input  funct3_t      funct3_i,
    input  funct7_t      funct7_i,
    output logic         valid_o,
    output decode_ctrl_t ctrl_o,
    output imm_fmt_t     imm_fmt_o
);

    logic         valid;
    decode_ctrl_t ctrl;
    imm_fmt_t     fmt;

    always_comb begin
        valid = 1'b0;
        ctrl  = CTRL_DEFAULT;
        fmt   = IMM_FMT_NONE;

        case (opcode_i)
            OPCODE_LUI: begin
                valid             = 1'b1;
                ctrl.alu_op       = ALU_OP_SRC2;
                ctrl.alu_src2     = ALU_SRC2_IMM;
                ctrl.rd_writeback = 1'b1;
                fmt               = IMM_FMT_U;
            end
            OPCODE_AUIPC: begin
                valid             = 1'b1;
                ctrl.alu_src1     = ALU_SRC1_PC;
                ctrl.alu_src2     = ALU_SRC2_IMM;
                ctrl.rd_writeback = 1'b1;
                fmt               = IMM_FMT_U;
            end
            OPCODE_JAL, OPCODE_JALR: begin
                // jalr only with funct3 zero.
                valid              = (opcode_i == OPCODE_JAL) || (funct3_i == FUNCT3_JALR);
                ctrl.alu_op        = ALU_OP_SRC1P4;
                ctrl.alu_src1      = ALU_SRC1_PC;
                ctrl.branch_op     = BRANCH_OP_ALWAYS;
                ctrl.rd_writeback  = 1'b1;
                if (opcode_i == OPCODE_JAL) begin
                    fmt = IMM_FMT_J;
                end else begin
                    ctrl.branch_pc_src = BRANCH_PC_SRC_REG;
                    fmt                = IMM_FMT_I;
                end
            end
            OPCODE_BRANCH: begin
                valid            = 1'b1;
                ctrl.alu_sub_sra = 1'b1; // compare by subtraction.
                fmt              = IMM_FMT_B;
                case (funct3_i)
                    FUNCT3_BEQ:  ctrl.branch_op = BRANCH_OP_ZERO;
                    FUNCT3_BNE:  ctrl.branch_op = BRANCH_OP_NON_ZERO;
                    FUNCT3_BLT: begin
                        ctrl.alu_op    = ALU_OP_SLT;
                        ctrl.branch_op = BRANCH_OP_NON_ZERO;
                    end
                    FUNCT3_BGE: begin
                        ctrl.alu_op    = ALU_OP_SLT;
                        ctrl.branch_op = BRANCH_OP_ZERO;
                    end
                    FUNCT3_BLTU: begin
                        ctrl.alu_op    = ALU_OP_SLTU;
                        ctrl.branch_op = BRANCH_OP_NON_ZERO;
                    end
                    FUNCT3_BGEU: begin
                        ctrl.alu_op    = ALU_OP_SLTU;
                        ctrl.branch_op = BRANCH_OP_ZERO;
                    end
                    default: valid = 1'b0;
                endcase
            end
            OPCODE_LOAD: begin
                valid                = 1'b1;
                ctrl.alu_src2        = ALU_SRC2_IMM;
                ctrl.mem_read_en     = 1'b1;
                ctrl.rd_writeback    = 1'b1;
                ctrl.mem_zero_extend = funct3_i[2]; // lbu and lhu.
                fmt                  = IMM_FMT_I;
                case (funct3_i)
                    FUNCT3_LB, FUNCT3_LBU: ctrl.mem_width = MEM_WIDTH_BYTE;
                    FUNCT3_LH, FUNCT3_LHU: ctrl.mem_width = MEM_WIDTH_HALF;
                    FUNCT3_LW:             ctrl.mem_width = MEM_WIDTH_WORD;
                    default:               valid = 1'b0;
                endcase
            end
            OPCODE_STORE: begin
                valid             = 1'b1;
                ctrl.alu_src2     = ALU_SRC2_IMM;
                ctrl.mem_write_en = 1'b1;
                fmt               = IMM_FMT_S;
                case (funct3_i)
                    FUNCT3_SB: ctrl.mem_width = MEM_WIDTH_BYTE;
                    FUNCT3_SH: ctrl.mem_width = MEM_WIDTH_HALF;
                    FUNCT3_SW: ctrl.mem_width = MEM_WIDTH_WORD;
                    default:   valid = 1'b0;
                endcase
            end
            OPCODE_OP_IMM, OPCODE_OP: begin
                // alu_op_t low codes match funct3.
                ctrl.alu_op       = alu_op_t'({1'b0, funct3_i});
                ctrl.alu_sub_sra  = (funct3_i == FUNCT3_SLT) || (funct3_i == FUNCT3_SLTU) ||
                                    (funct7_i == FUNCT7_SUB_SRA);
                ctrl.rd_writeback = 1'b1;
                if (opcode_i == OPCODE_OP_IMM) begin
                    ctrl.alu_src2 = ALU_SRC2_IMM;
                    case (funct3_i)
                        FUNCT3_SLL: begin
                            valid = (funct7_i == FUNCT7_ZERO);
                            fmt   = IMM_FMT_SHAMT;
                        end
                        FUNCT3_SRL_SRA: begin
                            valid = (funct7_i == FUNCT7_ZERO) || (funct7_i == FUNCT7_SUB_SRA);
                            fmt   = IMM_FMT_SHAMT;
                        end
                        default: begin
                            valid            = 1'b1;
                            fmt              = IMM_FMT_I;
                            // funct7 is immediate bits here.
                            ctrl.alu_sub_sra = (funct3_i == FUNCT3_SLT) ||
                                               (funct3_i == FUNCT3_SLTU);
                        end
                    endcase
                end else begin
                    valid = (funct7_i == FUNCT7_ZERO) ||
                            ((funct7_i == FUNCT7_SUB_SRA) &&
                             ((funct3_i == FUNCT3_ADD_SUB) || (funct3_i == FUNCT3_SRL_SRA)));
                end
            end
            OPCODE_MISC_MEM: begin
                // fences have no side effects here.
                valid = (funct3_i == FUNCT3_FENCE) || (funct3_i == FUNCT3_FENCE_I);
            end
            default: valid = 1'b0;
        endcase
    end

    assign valid_o   = valid;
    assign ctrl_o    = valid ? ctrl : CTRL_DEFAULT;
    assign imm_fmt_o = valid ? fmt : IMM_FMT_NONE;

endmodule

// File: verilog/rv32_decode.sv
module rv32_decode import rv32_pkg::*; (
    input  logic         clk,
    input  logic         rst_i,
    input  logic         stall_i,
    input  logic         flush_i,
    input  word_t        pc_i,
    input  word_t        instr_i,
    input  rf_write_t    wb_i,
    output logic         valid_o,
    output reg_idx_t     rs1_o,
    output reg_idx_t     rs2_o,
    output reg_idx_t     rd_o,
    output decode_ctrl_t ctrl_o,
    output word_t        pc_o,
    output word_t        imm_o,
    output word_t        rs1_value_o,
    output word_t        rs2_value_o
);

    funct7_t  funct7;
    reg_idx_t rs2;
    reg_idx_t rs1;
    funct3_t  funct3;
    reg_idx_t rd;
    opcode_t  opcode;

    assign funct7 = instr_i[31:25];
    assign rs2    = instr_i[24:20];
    assign rs1    = instr_i[19:15];
    assign funct3 = instr_i[14:12];
    assign rd     = instr_i[11:7];
    assign opcode = instr_i[6:0];

    logic         dec_valid;
    decode_ctrl_t dec_ctrl;
    imm_fmt_t     dec_fmt;
    word_t        dec_imm;

    rv32_ctrl_decode u_ctrl (
        .opcode_i  (opcode),
        .funct3_i  (funct3),
        .funct7_i  (funct7),
        .valid_o   (dec_valid),
        .ctrl_o    (dec_ctrl),
        .imm_fmt_o (dec_fmt)
    );

    rv32_imm_gen u_imm (
        .instr_i   (instr_i),
        .imm_fmt_i (dec_fmt),
        .imm_o     (dec_imm)
    );

    rv32_regfile u_regs (
        .clk         (clk),
        .stall_i     (stall_i),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .wb_i        (wb_i),
        .rs1_value_o (rs1_value_o),
        .rs2_value_o (rs2_value_o)
    );

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            ctrl_o  <= CTRL_DEFAULT;
        end else if (!stall_i) begin
            valid_o <= dec_valid;
            ctrl_o  <= dec_ctrl;
            if (flush_i) begin
                // drop side effects only.
                ctrl_o.mem_read_en  <= 1'b0;
                ctrl_o.mem_write_en <= 1'b0;
                ctrl_o.branch_op    <= BRANCH_OP_NEVER;
                ctrl_o.rd_writeback <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            rs1_o <= flush_i ? '0 : rs1;
            rs2_o <= flush_i ? '0 : rs2;
            rd_o  <= rd;
            pc_o  <= pc_i;
            imm_o <= dec_imm;
        end
    end

endmodule

// File: verilog/rv32_imm_gen.sv
module rv32_imm_gen import rv32_pkg::*; (
    input  word_t    instr_i,
    input  imm_fmt_t imm_fmt_i,
    output word_t    imm_o
);

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (imm_fmt_i)
            IMM_FMT_I: begin
                imm_o = {{21{sign}}, instr_i[30:20]};
            end
            IMM_FMT_S: begin
                imm_o = {{21{sign}}, instr_i[30:25], instr_i[11:7]};
            end
            IMM_FMT_B: begin
                imm_o = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            end
            IMM_FMT_U: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            IMM_FMT_J: begin
                imm_o = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            end
            IMM_FMT_SHAMT: begin
                imm_o = {27'b0, instr_i[24:20]}; // rs2 field, unsigned.
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

// File: verilog/rv32_pkg.sv
package rv32_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes, instr[6:0].
    localparam opcode_t OPCODE_LUI      = 7'b0110111;
    localparam opcode_t OPCODE_AUIPC    = 7'b0010111;
    localparam opcode_t OPCODE_JAL      = 7'b1101111;
    localparam opcode_t OPCODE_JALR     = 7'b1100111;
    localparam opcode_t OPCODE_BRANCH   = 7'b1100011;
    localparam opcode_t OPCODE_LOAD     = 7'b0000011;
    localparam opcode_t OPCODE_STORE    = 7'b0100011;
    localparam opcode_t OPCODE_OP_IMM   = 7'b0010011;
    localparam opcode_t OPCODE_OP       = 7'b0110011;
    localparam opcode_t OPCODE_MISC_MEM = 7'b0001111;

    localparam funct3_t FUNCT3_JALR     = 3'b000;

    localparam funct3_t FUNCT3_BEQ      = 3'b000;
    localparam funct3_t FUNCT3_BNE      = 3'b001;
    localparam funct3_t FUNCT3_BLT      = 3'b100;
    localparam funct3_t FUNCT3_BGE      = 3'b101;
    localparam funct3_t FUNCT3_BLTU     = 3'b110;
    localparam funct3_t FUNCT3_BGEU     = 3'b111;

    localparam funct3_t FUNCT3_LB       = 3'b000;
    localparam funct3_t FUNCT3_LH       = 3'b001;
    localparam funct3_t FUNCT3_LW       = 3'b010;
    localparam funct3_t FUNCT3_LBU      = 3'b100;
    localparam funct3_t FUNCT3_LHU      = 3'b101;

    localparam funct3_t FUNCT3_SB       = 3'b000;
    localparam funct3_t FUNCT3_SH       = 3'b001;
    localparam funct3_t FUNCT3_SW       = 3'b010;

    localparam funct3_t FUNCT3_ADD_SUB  = 3'b000;
    localparam funct3_t FUNCT3_SLL      = 3'b001;
    localparam funct3_t FUNCT3_SLT      = 3'b010;
    localparam funct3_t FUNCT3_SLTU     = 3'b011;
    localparam funct3_t FUNCT3_XOR      = 3'b100;
    localparam funct3_t FUNCT3_SRL_SRA  = 3'b101;
    localparam funct3_t FUNCT3_OR       = 3'b110;
    localparam funct3_t FUNCT3_AND      = 3'b111;

    localparam funct3_t FUNCT3_FENCE    = 3'b000;
    localparam funct3_t FUNCT3_FENCE_I  = 3'b001;

    localparam funct7_t FUNCT7_ZERO     = 7'b0000000;
    localparam funct7_t FUNCT7_SUB_SRA  = 7'b0100000;

    // first eight follow the OP funct3 order.
    typedef enum logic [3:0] {
        ALU_OP_ADD_SUB = 4'd0,
        ALU_OP_SLL     = 4'd1,
        ALU_OP_SLT     = 4'd2,
        ALU_OP_SLTU    = 4'd3,
        ALU_OP_XOR     = 4'd4,
        ALU_OP_SRL_SRA = 4'd5,
        ALU_OP_OR      = 4'd6,
        ALU_OP_AND     = 4'd7,
        ALU_OP_SRC2    = 4'd8,
        ALU_OP_SRC1P4  = 4'd9
    } alu_op_t;

    typedef enum logic {
        ALU_SRC1_REG = 1'b0,
        ALU_SRC1_PC  = 1'b1
    } alu_src1_t;

    typedef enum logic {
        ALU_SRC2_REG = 1'b0,
        ALU_SRC2_IMM = 1'b1
    } alu_src2_t;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE = 2'd0,
        MEM_WIDTH_HALF = 2'd1,
        MEM_WIDTH_WORD = 2'd2
    } mem_width_t;

    typedef enum logic [1:0] {
        BRANCH_OP_NEVER    = 2'd0,
        BRANCH_OP_ZERO     = 2'd1,
        BRANCH_OP_NON_ZERO = 2'd2,
        BRANCH_OP_ALWAYS   = 2'd3
    } branch_op_t;

    typedef enum logic {
        BRANCH_PC_SRC_IMM = 1'b0,
        BRANCH_PC_SRC_REG = 1'b1
    } branch_pc_src_t;

    typedef enum logic [2:0] {
        IMM_FMT_NONE,
        IMM_FMT_I,
        IMM_FMT_S,
        IMM_FMT_B,
        IMM_FMT_U,
        IMM_FMT_J,
        IMM_FMT_SHAMT
    } imm_fmt_t;

    typedef struct packed {
        alu_op_t        alu_op;
        logic           alu_sub_sra;
        alu_src1_t      alu_src1;
        alu_src2_t      alu_src2;
        logic           mem_read_en;
        logic           mem_write_en;
        mem_width_t     mem_width;
        logic           mem_zero_extend;
        branch_op_t     branch_op;
        branch_pc_src_t branch_pc_src;
        logic           rd_writeback;
    } decode_ctrl_t;

    localparam decode_ctrl_t CTRL_DEFAULT = '{
        alu_op:          ALU_OP_ADD_SUB,
        alu_sub_sra:     1'b0,
        alu_src1:        ALU_SRC1_REG,
        alu_src2:        ALU_SRC2_REG,
        mem_read_en:     1'b0,
        mem_write_en:    1'b0,
        mem_width:       MEM_WIDTH_WORD,
        mem_zero_extend: 1'b0,
        branch_op:       BRANCH_OP_NEVER,
        branch_pc_src:   BRANCH_PC_SRC_IMM,
        rd_writeback:    1'b0
    };

    typedef struct packed {
        reg_idx_t rd;
        logic     en;
        word_t    value;
    } rf_write_t;

endpackage

// File: verilog/rv32_regfile.sv
module rv32_regfile import rv32_pkg::*; (
    input  logic      clk,
    input  logic      stall_i,
    input  reg_idx_t  rs1_i,
    input  reg_idx_t  rs2_i,
    input  rf_write_t wb_i,
    output word_t     rs1_value_o,
    output word_t     rs2_value_o
);

    word_t regs [31:1]; // x0 has no storage.

    logic wr_en;

    assign wr_en = wb_i.en && (wb_i.rd != '0);

    // read with bypass from the write port.
    function automatic word_t read_reg(input reg_idx_t idx);
        word_t value;
        if (idx == '0) begin
            value = '0;
        end else if (wr_en && (wb_i.rd == idx)) begin
            value = wb_i.value;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    // writes go ahead during a stall.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wb_i.rd] <= wb_i.value;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            rs1_value_o <= read_reg(rs1_i);
            rs2_value_o <= read_reg(rs2_i);
        end
    end

endmodule
